//--- common/rv_pkg.sv
// rv32i subset core shared types, opcodes, stage encoding and control word
package rv_pkg;

	typedef logic [31:0] word_t;    // register value, instruction, bus data
	typedef logic [31:2] wadr_t;    // word address
	typedef logic [4:0]  reg_adr_t; // register index

	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		ALU_PASS_B = 3'd5 // lui
	} alu_op_t;

	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		PC    = 3'd1,
		IMR   = 3'd2, // instruction read
		IDRFR = 3'd3, // decode and register read
		EX    = 3'd4,
		DMRW  = 3'd5  // data read/write and write back
	} cpu_stage_t;

	typedef struct packed {
		alu_op_t  alu_op;
		logic     use_imm; // operand b from immediate
		logic     is_ld;
		logic     is_st;
		logic     is_br;
		logic     br_ne;   // bne, else beq
		logic     is_jal;
		logic     wbk;     // write rd at dmrw end
		reg_adr_t rd;
		word_t    imm;
	} ctrl_t;

	// major opcodes
	localparam logic [6:0] OP_LUI  = 7'b0110111;
	localparam logic [6:0] OP_ALUI = 7'b0010011;
	localparam logic [6:0] OP_ALU  = 7'b0110011;
	localparam logic [6:0] OP_LD   = 7'b0000011;
	localparam logic [6:0] OP_ST   = 7'b0100011;
	localparam logic [6:0] OP_BR   = 7'b1100011;
	localparam logic [6:0] OP_JAL  = 7'b1101111;

	localparam word_t NOP_INST = 32'h0000_0013; // addi x0,x0,0

endpackage

//--- src/cpu_sequencer.sv
// run control, five-stage sequencing FSM and program counter
`timescale 1ns/10ps

module cpu_sequencer (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_cpu_start,
	input  rv_pkg::wadr_t      i_start_adr,
	input  logic               i_quit_cmd,
	input  logic               i_imr_done,
	input  logic               i_dmrw_done,
	input  rv_pkg::wadr_t      i_next_pc,
	output rv_pkg::cpu_stage_t o_stage,
	output rv_pkg::wadr_t      o_pc
);

	logic run;       // core is executing
	logic quit_pend; // quit seen, stop after current instruction

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_stage   <= rv_pkg::IDLE;
			o_pc      <= '0;
			run       <= 1'b0;
			quit_pend <= 1'b0;
		end else begin
			if (run && i_quit_cmd)
				quit_pend <= 1'b1; // remembered until dmrw ends

			case (o_stage)
			rv_pkg::IDLE: begin
				if (i_cpu_start) begin
					o_pc    <= i_start_adr;
					run     <= 1'b1;
					o_stage <= rv_pkg::PC;
				end
			end
			rv_pkg::PC: begin
				o_stage <= rv_pkg::IMR; // fetch request rises here
			end
			rv_pkg::IMR: begin
				if (i_imr_done)
					o_stage <= rv_pkg::IDRFR;
			end
			rv_pkg::IDRFR: begin
				o_stage <= rv_pkg::EX;
			end
			rv_pkg::EX: begin
				o_stage <= rv_pkg::DMRW;
			end
			rv_pkg::DMRW: begin
				if (i_dmrw_done) begin
					o_pc <= i_next_pc; // instruction retires
					if (quit_pend || i_quit_cmd) begin
						o_stage   <= rv_pkg::IDLE;
						run       <= 1'b0;
						quit_pend <= 1'b0;
					end else begin
						o_stage <= rv_pkg::PC;
					end
				end
			end
			default: begin
				o_stage <= rv_pkg::IDLE;
			end
			endcase
		end
	end

endmodule

//--- src/mem_port.sv
// shared memory bus master for instruction fetch, loads and stores, plus write-back select
`timescale 1ns/10ps

module mem_port (
	input  logic               clk,
	input  logic               i_rst,
	input  rv_pkg::cpu_stage_t i_stage,
	input  rv_pkg::wadr_t      i_pc,
	input  rv_pkg::ctrl_t      i_ctrl,
	input  rv_pkg::word_t      i_data_adr,
	input  rv_pkg::word_t      i_st_data,
	input  rv_pkg::word_t      i_ex_result,
	input  logic               i_read_valid,
	input  rv_pkg::word_t      i_read_data,
	input  logic               i_write_finish,
	output logic               o_read_req,
	output rv_pkg::word_t      o_read_adr,
	output logic               o_write_req,
	output rv_pkg::word_t      o_write_adr,
	output rv_pkg::word_t      o_write_data,
	output rv_pkg::word_t      o_inst,
	output logic               o_imr_done,
	output logic               o_dmrw_done,
	output logic               o_wbk_en,
	output rv_pkg::reg_adr_t   o_wbk_rd,
	output rv_pkg::word_t      o_wbk_data
);

	logic rd_hit; // read answered
	logic wr_hit; // write answered
	logic in_dmrw;

	assign rd_hit  = o_read_req & i_read_valid;
	assign wr_hit  = o_write_req & i_write_finish;
	assign in_dmrw = (i_stage == rv_pkg::DMRW);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_read_req  <= 1'b0;
			o_write_req <= 1'b0;
			o_imr_done  <= 1'b0;
			o_inst      <= rv_pkg::NOP_INST;
		end else begin
			o_imr_done <= rd_hit && (i_stage == rv_pkg::IMR); // imr ends a cycle later
			if (rd_hit && (i_stage == rv_pkg::IMR))
				o_inst <= i_read_data;

			if (rd_hit)
				o_read_req <= 1'b0;
			else if ((i_stage == rv_pkg::PC) || (in_dmrw && i_ctrl.is_ld))
				o_read_req <= 1'b1; // dmrw: only first cycle, req is low then

			if (wr_hit)
				o_write_req <= 1'b0;
			else if (in_dmrw && i_ctrl.is_st)
				o_write_req <= 1'b1;
		end
	end

	// address and data frozen while a request is up
	always_ff @(posedge clk) begin
		if (!o_read_req)
			o_read_adr <= in_dmrw ? i_data_adr : {i_pc, 2'b00};
		if (!o_write_req) begin
			o_write_adr  <= i_data_adr;
			o_write_data <= i_st_data;
		end
	end

	always_comb begin
		if (i_ctrl.is_ld)
			o_dmrw_done = in_dmrw & rd_hit;
		else if (i_ctrl.is_st)
			o_dmrw_done = in_dmrw & wr_hit;
		else
			o_dmrw_done = in_dmrw; // one cycle for non-memory ops
	end

	assign o_wbk_en   = o_dmrw_done & i_ctrl.wbk;
	assign o_wbk_rd   = i_ctrl.rd;
	assign o_wbk_data = i_ctrl.is_ld ? i_read_data : i_ex_result;

endmodule

//--- decode/decoder.sv
// instruction decoder producing the control word, immediate and source indices
`timescale 1ns/10ps

module decoder (
	input  rv_pkg::word_t    i_inst,
	output rv_pkg::ctrl_t    o_ctrl,
	output rv_pkg::reg_adr_t o_rs1,
	output rv_pkg::reg_adr_t o_rs2
);

	logic [6:0]    opcode;
	logic [2:0]    funct3;
	rv_pkg::word_t imm_i;
	rv_pkg::word_t imm_s;
	rv_pkg::word_t imm_b;
	rv_pkg::word_t imm_j;
	rv_pkg::word_t imm_u;

	assign opcode = i_inst[6:0];
	assign funct3 = i_inst[14:12];
	assign o_rs1  = i_inst[19:15];
	assign o_rs2  = i_inst[24:20];

	// sign-extended immediates per format
	assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
	assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
	assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
		i_inst[11:8], 1'b0};
	assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
		i_inst[30:21], 1'b0};
	assign imm_u = {i_inst[31:12], 12'h000};

	always_comb begin
		o_ctrl = '0; // no-op unless recognized
		case (opcode)
		rv_pkg::OP_LUI: begin
			o_ctrl.alu_op  = rv_pkg::ALU_PASS_B;
			o_ctrl.use_imm = 1'b1;
			o_ctrl.imm     = imm_u;
			o_ctrl.rd      = i_inst[11:7];
			o_ctrl.wbk     = 1'b1;
		end
		rv_pkg::OP_ALUI, rv_pkg::OP_ALU: begin
			o_ctrl.use_imm = (opcode == rv_pkg::OP_ALUI);
			o_ctrl.imm     = imm_i;
			o_ctrl.rd      = i_inst[11:7];
			o_ctrl.wbk     = 1'b1;
			case (funct3)
			3'b000: o_ctrl.alu_op = ((opcode == rv_pkg::OP_ALU) && i_inst[30]) ?
				rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b100: o_ctrl.alu_op = rv_pkg::ALU_XOR;
			3'b110: o_ctrl.alu_op = rv_pkg::ALU_OR;
			3'b111: o_ctrl.alu_op = rv_pkg::ALU_AND;
			default: o_ctrl.wbk = 1'b0; // shifts, slt: not supported
			endcase
		end
		rv_pkg::OP_LD: begin
			o_ctrl.is_ld = (funct3 == 3'b010); // lw only
			o_ctrl.wbk   = (funct3 == 3'b010);
			o_ctrl.imm   = imm_i;
			o_ctrl.rd    = i_inst[11:7];
		end
		rv_pkg::OP_ST: begin
			o_ctrl.is_st = (funct3 == 3'b010); // sw only
			o_ctrl.imm   = imm_s;
		end
		rv_pkg::OP_BR: begin
			o_ctrl.is_br = (funct3 == 3'b000) || (funct3 == 3'b001);
			o_ctrl.br_ne = funct3[0];
			o_ctrl.imm   = imm_b;
		end
		rv_pkg::OP_JAL: begin
			o_ctrl.is_jal = 1'b1;
			o_ctrl.imm    = imm_j;
			o_ctrl.rd     = i_inst[11:7];
			o_ctrl.wbk    = 1'b1; // link
		end
		default: begin
			o_ctrl = '0;
		end
		endcase
	end

endmodule

//--- decode/register_file.sv
// 32 x 32-bit register file with x0 tied to zero, registered reads in decode stage
`timescale 1ns/10ps

module register_file (
	input  logic               clk,
	input  logic               i_rst,
	input  rv_pkg::cpu_stage_t i_stage,
	input  rv_pkg::reg_adr_t   i_rs1,
	input  rv_pkg::reg_adr_t   i_rs2,
	input  logic               i_wbk_en,
	input  rv_pkg::reg_adr_t   i_wbk_rd,
	input  rv_pkg::word_t      i_wbk_data,
	output rv_pkg::word_t      o_rs1_data,
	output rv_pkg::word_t      o_rs2_data
);

	rv_pkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (i_rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (i_wbk_en && (i_wbk_rd != 5'd0)) begin
			regs[i_wbk_rd] <= i_wbk_data; // x0 never written
		end
	end

	// operands captured at the end of idrfr
	always_ff @(posedge clk) begin
		if (i_stage == rv_pkg::IDRFR) begin
			o_rs1_data <= regs[i_rs1];
			o_rs2_data <= regs[i_rs2];
		end
	end

endmodule

//--- src/execution.sv
// alu, branch compare, jump target and next pc, all registered in the execute stage
`timescale 1ns/10ps

module execution (
	input  logic               clk,
	input  logic               i_rst,
	input  rv_pkg::cpu_stage_t i_stage,
	input  rv_pkg::ctrl_t      i_ctrl,
	input  rv_pkg::word_t      i_rs1_data,
	input  rv_pkg::word_t      i_rs2_data,
	input  rv_pkg::wadr_t      i_pc,
	output rv_pkg::ctrl_t      o_ctrl_ex,
	output rv_pkg::word_t      o_ex_result,
	output rv_pkg::word_t      o_data_adr,
	output rv_pkg::word_t      o_st_data,
	output rv_pkg::wadr_t      o_next_pc
);

	rv_pkg::word_t op_b;
	rv_pkg::word_t alu_out;
	rv_pkg::wadr_t pc_seq;  // pc plus one word
	rv_pkg::wadr_t jmp_adr; // branch or jal target
	logic          br_take;
	logic          take_q;
	rv_pkg::wadr_t jmp_adr_q;

	assign op_b    = i_ctrl.use_imm ? i_ctrl.imm : i_rs2_data;
	assign pc_seq  = i_pc + 30'd1;
	assign jmp_adr = i_pc + i_ctrl.imm[31:2];

	always_comb begin
		case (i_ctrl.alu_op)
		rv_pkg::ALU_ADD:    alu_out = i_rs1_data + op_b;
		rv_pkg::ALU_SUB:    alu_out = i_rs1_data - op_b;
		rv_pkg::ALU_AND:    alu_out = i_rs1_data & op_b;
		rv_pkg::ALU_OR:     alu_out = i_rs1_data | op_b;
		rv_pkg::ALU_XOR:    alu_out = i_rs1_data ^ op_b;
		rv_pkg::ALU_PASS_B: alu_out = op_b;
		default:            alu_out = '0;
		endcase
	end

	// beq / bne compare
	assign br_take = i_ctrl.is_br &
		(i_ctrl.br_ne ? (i_rs1_data != i_rs2_data) : (i_rs1_data == i_rs2_data));

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_ctrl_ex <= '0;
			take_q    <= 1'b0;
		end else if (i_stage == rv_pkg::EX) begin
			o_ctrl_ex <= i_ctrl;
			take_q    <= br_take | i_ctrl.is_jal;
		end
	end

	always_ff @(posedge clk) begin
		if (i_stage == rv_pkg::EX) begin
			o_ex_result <= i_ctrl.is_jal ? {pc_seq, 2'b00} : alu_out; // jal links pc+4
			o_data_adr  <= i_rs1_data + i_ctrl.imm;
			o_st_data   <= i_rs2_data;
			jmp_adr_q   <= jmp_adr;
		end
	end

	// pc is stable until dmrw ends
	assign o_next_pc = take_q ? jmp_adr_q : i_pc + 30'd1;

endmodule

//--- src/cpu_top.sv
// multi-cycle rv32i subset core, connects sequencer, decode, register file, execution and bus
`timescale 1ns/10ps

module cpu_top (
	input  logic          clk,
	input  logic          i_rst,
	input  logic          i_cpu_start,
	input  rv_pkg::wadr_t i_start_adr,
	input  logic          i_quit_cmd,
	output rv_pkg::word_t o_pc_data,

	output logic          o_read_req,
	output rv_pkg::word_t o_read_adr,
	input  logic          i_read_valid,
	input  rv_pkg::word_t i_read_data,
	output logic          o_write_req,
	output rv_pkg::word_t o_write_adr,
	output rv_pkg::word_t o_write_data,
	input  logic          i_write_finish
);

	rv_pkg::cpu_stage_t stage;
	rv_pkg::wadr_t      pc;
	rv_pkg::wadr_t      next_pc;
	rv_pkg::ctrl_t      ctrl;    // from decoder
	rv_pkg::ctrl_t      ctrl_ex; // registered in ex
	rv_pkg::reg_adr_t   rs1;
	rv_pkg::reg_adr_t   rs2;
	rv_pkg::word_t      rs1_data;
	rv_pkg::word_t      rs2_data;
	rv_pkg::word_t      inst;
	rv_pkg::word_t      ex_result;
	rv_pkg::word_t      data_adr;
	rv_pkg::word_t      st_data;
	rv_pkg::reg_adr_t   wbk_rd;
	rv_pkg::word_t      wbk_data;
	logic               imr_done;
	logic               dmrw_done;
	logic               wbk_en;

	assign o_pc_data = {pc, 2'b00};

	cpu_sequencer cpu_sequencer (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_cpu_start (i_cpu_start),
		.i_start_adr (i_start_adr),
		.i_quit_cmd  (i_quit_cmd),
		.i_imr_done  (imr_done),
		.i_dmrw_done (dmrw_done),
		.i_next_pc   (next_pc),
		.o_stage     (stage),
		.o_pc        (pc)
	);

	decoder decoder (
		.i_inst (inst),
		.o_ctrl (ctrl),
		.o_rs1  (rs1),
		.o_rs2  (rs2)
	);

	register_file register_file (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_stage    (stage),
		.i_rs1      (rs1),
		.i_rs2      (rs2),
		.i_wbk_en   (wbk_en),
		.i_wbk_rd   (wbk_rd),
		.i_wbk_data (wbk_data),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	execution execution (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_stage     (stage),
		.i_ctrl      (ctrl),
		.i_rs1_data  (rs1_data),
		.i_rs2_data  (rs2_data),
		.i_pc        (pc),
		.o_ctrl_ex   (ctrl_ex),
		.o_ex_result (ex_result),
		.o_data_adr  (data_adr),
		.o_st_data   (st_data),
		.o_next_pc   (next_pc)
	);

	mem_port mem_port (
		.clk            (clk),
		.i_rst          (i_rst),
		.i_stage        (stage),
		.i_pc           (pc),
		.i_ctrl         (ctrl_ex),
		.i_data_adr     (data_adr),
		.i_st_data      (st_data),
		.i_ex_result    (ex_result),
		.i_read_valid   (i_read_valid),
		.i_read_data    (i_read_data),
		.i_write_finish (i_write_finish),
		.o_read_req     (o_read_req),
		.o_read_adr     (o_read_adr),
		.o_write_req    (o_write_req),
		.o_write_adr    (o_write_adr),
		.o_write_data   (o_write_data),
		.o_inst         (inst),
		.o_imr_done     (imr_done),
		.o_dmrw_done    (dmrw_done),
		.o_wbk_en       (wbk_en),
		.o_wbk_rd       (wbk_rd),
		.o_wbk_data     (wbk_data)
	);

endmodule

//--- tb/cpu_top_assertions.sv
// bus protocol checks on the core's shared memory port
`timescale 1ns/10ps

module cpu_top_assertions (
	input logic          clk,
	input logic          i_rst,
	input logic          o_read_req,
	input rv_pkg::word_t o_read_adr,
	input logic          i_read_valid,
	input logic          o_write_req,
	input rv_pkg::word_t o_write_adr,
	input rv_pkg::word_t o_write_data,
	input logic          i_write_finish
);

	// request held with stable address until answered
	assert property (@(posedge clk) disable iff (i_rst)
		(o_read_req && !i_read_valid) |=> (o_read_req && $stable(o_read_adr)))
		else $error("read request dropped or address changed before valid");

	assert property (@(posedge clk) disable iff (i_rst)
		(o_write_req && !i_write_finish) |=>
		(o_write_req && $stable(o_write_adr) && $stable(o_write_data)))
		else $error("write request dropped or changed before finish");

	assert property (@(posedge clk) !(o_read_req && o_write_req))
		else $error("read and write requests high together");

	assert property (@(posedge clk) $past(i_rst) |-> (!o_read_req && !o_write_req))
		else $error("bus request high right after reset");

endmodule

bind cpu_top cpu_top_assertions i_cpu_top_assertions (.*);

//--- tb/tb_cpu_top.sv
// testbench for the rv32i subset core, runs small programs against a bus memory model
`timescale 1ns/10ps

module tb_cpu_top;

	localparam int NT          = 5;   // program table entries
	localparam int MEM_WORDS   = 256;
	localparam int CYCLE_LIMIT = NT * 8 * 12 + 600;

	logic          clk;
	logic          i_rst;
	logic          i_cpu_start;
	rv_pkg::wadr_t i_start_adr;
	logic          i_quit_cmd;
	rv_pkg::word_t o_pc_data;
	logic          o_read_req;
	rv_pkg::word_t o_read_adr;
	logic          i_read_valid;
	rv_pkg::word_t i_read_data;
	logic          o_write_req;
	rv_pkg::word_t o_write_adr;
	rv_pkg::word_t o_write_data;
	logic          i_write_finish;

	rv_pkg::word_t mem [MEM_WORDS];
	rv_pkg::word_t rd_adr_q [$];  // every answered read
	rv_pkg::word_t wr_adr_q [$];  // every answered write
	rv_pkg::word_t wr_data_q [$];
	int            rd_wait;
	int            wr_wait;
	int            cycle = 0;
	int            value_errs = 0;
	int            other_errs = 0;

	// program table
	string         t_name [NT];
	rv_pkg::wadr_t t_start [NT];
	rv_pkg::word_t t_prog [NT][8];
	rv_pkg::word_t t_exp_adr [NT];
	rv_pkg::word_t t_exp_data [NT];
	rv_pkg::word_t t_exp_pc [NT]; // pc once the core has stopped

	cpu_top i_cpu_top (
		.clk            (clk),
		.i_rst          (i_rst),
		.i_cpu_start    (i_cpu_start),
		.i_start_adr    (i_start_adr),
		.i_quit_cmd     (i_quit_cmd),
		.o_pc_data      (o_pc_data),
		.o_read_req     (o_read_req),
		.o_read_adr     (o_read_adr),
		.i_read_valid   (i_read_valid),
		.i_read_data    (i_read_data),
		.o_write_req    (o_write_req),
		.o_write_adr    (o_write_adr),
		.o_write_data   (o_write_data),
		.i_write_finish (i_write_finish)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout: the core did not finish the programs in %0d cycles", cycle);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// bus memory model, random 0..3 cycle answer delay
	initial begin
		i_read_valid   = 1'b0;
		i_read_data    = '0;
		i_write_finish = 1'b0;
		rd_wait        = 0;
		wr_wait        = 0;
		forever begin
			@(posedge clk);
			#1;
			i_read_valid   = 1'b0;
			i_write_finish = 1'b0;
			if (o_read_req) begin
				if (rd_wait == 0) begin
					i_read_valid = 1'b1;
					i_read_data  = mem[o_read_adr[9:2]];
					rd_adr_q.push_back(o_read_adr);
					rd_wait = int'($urandom % 4);
				end else begin
					rd_wait = rd_wait - 1;
				end
			end
			if (o_write_req) begin
				if (wr_wait == 0) begin
					i_write_finish = 1'b1;
					wr_adr_q.push_back(o_write_adr);
					wr_data_q.push_back(o_write_data);
					wr_wait = int'($urandom % 4);
				end else begin
					wr_wait = wr_wait - 1;
				end
			end
		end
	end

	// instruction encoders
	function automatic rv_pkg::word_t addi(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	function automatic rv_pkg::word_t lw(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic rv_pkg::word_t sw(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic rv_pkg::word_t rtype(input int f7, input int f3, input int rd,
		input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic rv_pkg::word_t branch(input int f3, input int rs1, input int rs2,
		input int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic rv_pkg::word_t lui(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic rv_pkg::word_t jal(input int rd, input int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	// opcode bits stay zero, so the fill executes as no-ops
	function automatic rv_pkg::word_t fill_word(input int idx);
		logic [7:0] b;
		b = idx[7:0];
		return {b, b ^ 8'h5a, b, 8'h80};
	endfunction

	task automatic set_entry(input int idx, input string name, input rv_pkg::wadr_t start,
		input rv_pkg::word_t exp_adr, input rv_pkg::word_t exp_data,
		input rv_pkg::word_t exp_pc);
		t_name[idx]     = name;
		t_start[idx]    = start;
		t_exp_adr[idx]  = exp_adr;
		t_exp_data[idx] = exp_data;
		t_exp_pc[idx]   = exp_pc;
	endtask

	task automatic build_table();
		for (int e = 0; e < NT; e++)
			for (int k = 0; k < 8; k++)
				t_prog[e][k] = '0;
		set_entry(0, "alu", 30'd128, 32'h0000_0110, 32'h0000_1000, 32'h0000_0224);
		t_prog[0][0] = lui(1, 'h12345);
		t_prog[0][1] = addi(2, 0, 'h0f0);
		t_prog[0][2] = rtype('h00, 0, 3, 1, 2); // add
		t_prog[0][3] = rtype('h20, 0, 4, 1, 2); // sub
		t_prog[0][4] = rtype('h00, 7, 5, 3, 4); // and
		t_prog[0][5] = rtype('h00, 6, 6, 5, 2); // or
		t_prog[0][6] = rtype('h00, 4, 7, 6, 3); // xor
		t_prog[0][7] = sw(7, 2, 'h20);
		set_entry(1, "load_store", 30'd144, 32'h0000_0180, 32'h401a_4080, 32'h0000_0250);
		t_prog[1][0] = addi(2, 0, 'h100);
		t_prog[1][1] = lw(1, 2, 0);
		t_prog[1][2] = sw(1, 2, 'h80);
		set_entry(2, "beq", 30'd160, 32'h0000_01c0, 32'h0000_0033, 32'h0000_02a0);
		t_prog[2][0] = addi(1, 0, 5);
		t_prog[2][1] = addi(2, 0, 5);
		t_prog[2][2] = branch(1, 1, 2, 8); // bne, not taken
		t_prog[2][3] = branch(0, 1, 2, 8); // beq, taken
		t_prog[2][4] = sw(1, 0, 'h1c0);
		t_prog[2][5] = addi(3, 0, 'h33);
		t_prog[2][6] = sw(3, 0, 'h1c0);
		set_entry(3, "bne", 30'd176, 32'h0000_01c4, 32'h0000_0044, 32'h0000_02e0);
		t_prog[3][0] = addi(1, 0, 5);
		t_prog[3][1] = addi(2, 0, 7);
		t_prog[3][2] = branch(0, 1, 2, 8); // beq, not taken
		t_prog[3][3] = branch(1, 1, 2, 8); // bne, taken
		t_prog[3][4] = sw(1, 0, 'h1c4);
		t_prog[3][5] = addi(3, 0, 'h44);
		t_prog[3][6] = sw(3, 0, 'h1c4);
		set_entry(4, "jal", 30'd192, 32'h0000_01c8, 32'h0000_0308, 32'h0000_0314);
		t_prog[4][0] = addi(1, 0, 'h11);
		t_prog[4][1] = jal(5, 8);
		t_prog[4][2] = sw(1, 0, 'h1c8);
		t_prog[4][3] = sw(5, 0, 'h1c8);
	endtask

	task automatic check_word(input string name, input rv_pkg::word_t exp,
		input rv_pkg::word_t act);
		if (exp !== act) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			value_errs = value_errs + 1;
		end
	endtask

	task automatic check_adr(input string name, input rv_pkg::wadr_t exp,
		input rv_pkg::wadr_t act);
		if (exp !== act) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			value_errs = value_errs + 1;
		end
	endtask

	task automatic load_program(input int t);
		int base;
		base = int'(t_start[t][9:2]);
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = fill_word(i);
		for (int k = 0; k < 8; k++)
			mem[base + k] = t_prog[t][k];
	endtask

	task automatic run_entry(input int t);
		int   rd_base;
		int   wr_base;
		int   rd_stop;
		logic late_req;
		load_program(t);
		rd_base  = rd_adr_q.size();
		wr_base  = wr_adr_q.size();
		late_req = 1'b0;
		@(posedge clk);
		#1;
		i_start_adr = t_start[t];
		i_cpu_start = 1'b1;
		@(posedge clk);
		#1;
		i_cpu_start = 1'b0;
		// write log settles by mid-cycle
		while (wr_adr_q.size() == wr_base)
			@(negedge clk);
		@(posedge clk);
		#1;
		i_quit_cmd = 1'b1; // pc stage of the instruction after the store
		@(posedge clk);
		#1;
		i_quit_cmd = 1'b0;
		while (i_cpu_top.stage != rv_pkg::IDLE) begin
			@(posedge clk);
			#1;
		end
		rd_stop = rd_adr_q.size();
		repeat (5) begin
			@(posedge clk);
			#1;
			if (o_read_req || o_write_req)
				late_req = 1'b1;
		end
		if (late_req || (rd_adr_q.size() != rd_stop)) begin
			$display("%s: a bus request appeared after the core stopped", t_name[t]);
			other_errs = other_errs + 1;
		end
		check_adr({t_name[t], " start adr"}, t_start[t], rd_adr_q[rd_base][31:2]);
		check_word({t_name[t], " store adr"}, t_exp_adr[t], wr_adr_q[wr_base]);
		check_word({t_name[t], " store data"}, t_exp_data[t], wr_data_q[wr_base]);
		check_word({t_name[t], " pc after quit"}, t_exp_pc[t], o_pc_data);
	endtask

	initial begin
		void'($urandom(32'hf642));
		clk         = 1'b0;
		i_rst       = 1'b1;
		i_cpu_start = 1'b0;
		i_start_adr = '0;
		i_quit_cmd  = 1'b0;
		build_table();
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = fill_word(i);
		repeat (8) @(posedge clk);
		#1;
		i_rst = 1'b0;
		for (int t = 0; t < NT; t++)
			run_entry(t);
		$display("summary: %0d value errors, %0d other errors", value_errs, other_errs);
		if ((value_errs + other_errs) == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- cpu_top.f
common/rv_pkg.sv
src/cpu_sequencer.sv
src/mem_port.sv
decode/decoder.sv
decode/register_file.sv
src/execution.sv
src/cpu_top.sv
tb/cpu_top_assertions.sv
tb/tb_cpu_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with verilator
rm -rf obj_dir
verilator --binary --timing --assert -sv --top-module tb_cpu_top -f cpu_top.f \
	-o sim_cpu_top > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_cpu_top > sim.log 2>&1
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" || \
	{ echo "simulation failed, see sim.log"; exit 1; }
